//--- project.f
logic/store_pkg.sv
logic/seq_buffer.sv
logic/nibble_cursor.sv
logic/store_commit_fsm.sv
logic/beat_packer.sv
logic/w_beat_fifo.sv
logic/seq_store_top.sv
verif/seq_store_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the store data path testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module seq_store_tb \
  -f project.f -o seq_store_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/seq_store_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- verif/seq_store_tb.sv
// Directed testbench for the sequential store data path
// Nibble-stream reference model, W beat monitor and cycle-count timeout

`timescale 1ns/1ps
`default_nettype none

module seq_store_tb;

  // Five tests need well under 200 cycles after reset
  localparam int CYCLE_LIMIT = 2000;
  localparam int STREAM_MAX  = 1024;

  logic                  clk_i = 1'b0;
  logic                  rst_ni;
  logic                  rx_deshfu_valid_i;
  logic                  rx_deshfu_ready_o;
  store_pkg::seq_entry_t rx_deshfu_i;
  logic                  txn_valid_i;
  logic                  txn_ready_o;
  store_pkg::txn_beat_t  txn_i;
  logic                  meta_valid_i;
  logic                  meta_ready_o;
  store_pkg::meta_t      meta_i;
  logic                  axi_w_valid_o;
  logic                  axi_w_ready_i;
  store_pkg::w_beat_t    axi_w_o;

  // ==========================================================================
  // Reference model state
  // ==========================================================================
  logic [3:0] stream_nb [STREAM_MAX];
  logic       stream_en [STREAM_MAX];
  int         gen_entries;
  int         rd_pos;
  bit         rand_en;
  integer     seed;
  int         errors;
  int         checks;
  int         cycle_cnt;
  logic [7:0] seen_strb;
  logic       seen_last;

  store_pkg::seq_entry_t entry_q [$];
  store_pkg::meta_t      meta_q [$];
  store_pkg::txn_beat_t  txn_q [$];
  store_pkg::w_beat_t    exp_q [$];

  seq_store_top uut (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .rx_deshfu_valid_i (rx_deshfu_valid_i),
    .rx_deshfu_ready_o (rx_deshfu_ready_o),
    .rx_deshfu_i       (rx_deshfu_i),
    .txn_valid_i       (txn_valid_i),
    .txn_ready_o       (txn_ready_o),
    .txn_i             (txn_i),
    .meta_valid_i      (meta_valid_i),
    .meta_ready_o      (meta_ready_o),
    .meta_i            (meta_i),
    .axi_w_valid_o     (axi_w_valid_o),
    .axi_w_ready_i     (axi_w_ready_i),
    .axi_w_o           (axi_w_o)
  );

  always #2 clk_i = ~clk_i;

  task automatic compare_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
    checks++;
    assert (actual === expected) else begin
      $display("FAILED at %0t: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
      errors++;
    end
  endtask

  // Appends one random entry to the nibble stream and to the send queue
  task automatic make_entry();
    store_pkg::seq_entry_t e;
    logic [31:0]           word;
    int                    base;
    base = gen_entries * store_pkg::SEQ_NIBBLES;
    for (int w = 0; w < 4; w++) begin
      word = $random(seed);
      for (int n = 0; n < 8; n++) begin
        e.nb[w*8+n] = word[4*n +: 4];
      end
    end
    word = rand_en ? $random(seed) : 32'hffff_ffff;
    e.en = word;
    for (int n = 0; n < store_pkg::SEQ_NIBBLES; n++) begin
      stream_nb[base+n] = e.nb[n];
      stream_en[base+n] = e.en[n];
    end
    entry_q.push_back(e);
    gen_entries++;
  endtask

  // Queues meta and txn words of one request and the beats it must produce
  task automatic plan_request(input logic [7:0] vstart, input logic [1:0] eew,
                              input int nbeats, input int addr_off, input int lbn,
                              input int burst_len);
    store_pkg::meta_t     m;
    store_pkg::txn_beat_t t;
    store_pkg::w_beat_t   w;
    int                   lower;
    int                   upper;
    m.vstart = vstart;
    m.eew    = eew;
    meta_q.push_back(m);
    // First nibble sits vstart elements into a fresh entry
    rd_pos = rd_pos + ((int'(vstart) << (eew + 1)) % store_pkg::SEQ_NIBBLES);
    for (int b = 0; b < nbeats; b++) begin
      t          = '0;
      t.is_head  = (b == 0);
      t.is_final = (b == nbeats - 1);
      // Bursts end every burst_len beats and at the final beat
      t.is_last  = t.is_final || (((b + 1) % burst_len) == 0);
      if (t.is_head) begin
        t.addr_off = 4'(addr_off);
      end
      if (t.is_last) begin
        t.lbn = t.is_final ? 5'(lbn) : 5'(store_pkg::BUS_NIBBLES);
      end
      txn_q.push_back(t);
      lower = t.is_head ? addr_off : 0;
      upper = t.is_last ? int'(t.lbn) : store_pkg::BUS_NIBBLES;
      w     = '0;
      for (int i = lower; i < upper; i++) begin
        while (rd_pos >= gen_entries * store_pkg::SEQ_NIBBLES) begin
          make_entry();
        end
        w.data[4*i +: 4] = stream_nb[rd_pos];
        if (stream_en[rd_pos]) begin
          w.strb[i/2] = 1'b1;
        end
        rd_pos++;
      end
      w.last = t.is_last;
      exp_q.push_back(w);
    end
    // Rest of the entry after the final beat is dropped
    rd_pos = ((rd_pos + store_pkg::SEQ_NIBBLES - 1) / store_pkg::SEQ_NIBBLES)
             * store_pkg::SEQ_NIBBLES;
  endtask

  // ==========================================================================
  // Drivers start and end on a falling edge
  // ==========================================================================
  task automatic send_entries();
    bit accepted;
    while (entry_q.size() > 0) begin
      rx_deshfu_valid_i = 1'b1;
      rx_deshfu_i       = entry_q.pop_front();
      do begin
        #1;
        accepted = rx_deshfu_ready_o;
        @(negedge clk_i);
      end while (!accepted);
    end
    rx_deshfu_valid_i = 1'b0;
  endtask

  task automatic send_meta();
    bit accepted;
    while (meta_q.size() > 0) begin
      meta_valid_i = 1'b1;
      meta_i       = meta_q.pop_front();
      do begin
        #1;
        accepted = meta_ready_o;
        @(negedge clk_i);
      end while (!accepted);
    end
    meta_valid_i = 1'b0;
  endtask

  task automatic send_txns();
    bit accepted;
    while (txn_q.size() > 0) begin
      txn_valid_i = 1'b1;
      txn_i       = txn_q.pop_front();
      do begin
        #1;
        accepted = txn_ready_o;
        @(negedge clk_i);
      end while (!accepted);
    end
    txn_valid_i = 1'b0;
  endtask

  task automatic run_traffic();
    fork
      send_entries();
      send_meta();
      send_txns();
    join
    while (exp_q.size() > 0) begin
      @(negedge clk_i);
    end
  endtask

  task automatic compare_beat();
    store_pkg::w_beat_t exp_beat;
    checks++;
    assert (exp_q.size() > 0) else begin
      $display("W beat at %0t arrived while no beat was expected", $time);
      errors++;
    end
    if (exp_q.size() > 0) begin
      exp_beat = exp_q.pop_front();
      compare_value("axi_w_o.data", exp_beat.data, axi_w_o.data);
      compare_value("axi_w_o.strb", 64'(exp_beat.strb), 64'(axi_w_o.strb));
      compare_value("axi_w_o.last", 64'(exp_beat.last), 64'(axi_w_o.last));
      seen_strb = axi_w_o.strb;
      seen_last = axi_w_o.last;
    end
  endtask

  // W monitor samples in the middle of the low phase
  always begin
    @(negedge clk_i);
    #1;
    if (rst_ni && axi_w_valid_o && axi_w_ready_i) begin
      compare_beat();
    end
  end

  // ==========================================================================
  // Directed tests
  // ==========================================================================
  task automatic test_reset_and_aligned();
    rand_en = 1'b0;
    #1;
    compare_value("axi_w_valid_o", 64'd0, 64'(axi_w_valid_o));
    compare_value("txn_ready_o", 64'd0, 64'(txn_ready_o));
    // Meta register starts empty
    compare_value("meta_ready_o", 64'd1, 64'(meta_ready_o));
    compare_value("rx_deshfu_ready_o", 64'd1, 64'(rx_deshfu_ready_o));
    @(negedge clk_i);
    plan_request(8'd0, 2'd0, 1, 0, 16, 1);
    run_traffic();
    compare_value("axi_w_o.strb", 64'hff, 64'(seen_strb));
    compare_value("axi_w_o.last", 64'd1, 64'(seen_last));
  endtask

  task automatic test_head_and_tail();
    rand_en = 1'b0;
    plan_request(8'd0, 2'd0, 3, 6, 9, 3);
    run_traffic();
  endtask

  task automatic test_entry_crossing();
    rand_en = 1'b1;
    plan_request(8'd5, 2'd1, 4, 0, 16, 4);
    plan_request(8'd7, 2'd2, 3, 3, 13, 3);
    run_traffic();
  endtask

  // Two bursts of four beats so that last and final differ
  task automatic test_backpressure();
    bit rx_stalled;
    rx_stalled    = 1'b0;
    rand_en       = 1'b1;
    axi_w_ready_i = 1'b0;
    plan_request(8'd3, 2'd0, 8, 0, 16, 4);
    fork
      run_traffic();
      begin
        repeat (60) begin
          @(negedge clk_i);
          #1;
          if (!rx_deshfu_ready_o) begin
            rx_stalled = 1'b1;
          end
        end
        @(negedge clk_i);
        axi_w_ready_i = 1'b1;
      end
    join
    checks++;
    assert (rx_stalled) else begin
      $display("rx_deshfu_ready_o never dropped while the W channel was held");
      errors++;
    end
  endtask

  task automatic test_final_discard();
    rand_en = 1'b0;
    plan_request(8'd2, 2'd0, 2, 0, 8, 2);
    plan_request(8'd6, 2'd0, 2, 2, 12, 2);
    run_traffic();
  endtask

  task automatic print_summary(input bit timed_out);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
  endtask

  initial begin
    seed              = 64;
    errors            = 0;
    checks            = 0;
    gen_entries       = 0;
    rd_pos            = 0;
    rand_en           = 1'b0;
    seen_strb         = '0;
    seen_last         = 1'b0;
    rst_ni            = 1'b0;
    rx_deshfu_valid_i = 1'b0;
    rx_deshfu_i       = '0;
    txn_valid_i       = 1'b0;
    txn_i             = '0;
    meta_valid_i      = 1'b0;
    meta_i            = '0;
    axi_w_ready_i     = 1'b1;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    test_reset_and_aligned();
    test_head_and_tail();
    test_entry_crossing();
    test_backpressure();
    test_final_discard();

    print_summary(1'b0);
    $finish;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    print_summary(1'b1);
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/seq_store_top.sv
// Top level of the sequential store data path
// Connects entry buffer, cursor, commit FSM, packer and W beat FIFO

`timescale 1ns/1ps
`default_nettype none

module seq_store_top (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,

  input  wire logic                  rx_deshfu_valid_i,
  output logic                       rx_deshfu_ready_o,
  input  wire store_pkg::seq_entry_t rx_deshfu_i,

  input  wire logic                  txn_valid_i,
  output logic                       txn_ready_o,
  input  wire store_pkg::txn_beat_t  txn_i,

  input  wire logic                  meta_valid_i,
  output logic                       meta_ready_o,
  input  wire store_pkg::meta_t      meta_i,

  output logic                       axi_w_valid_o,
  input  wire logic                  axi_w_ready_i,
  output store_pkg::w_beat_t         axi_w_o
);

  store_pkg::seq_entry_t          head;
  store_pkg::cursor_cmd_t         cursor_cmd;
  store_pkg::pack_win_t           win;
  store_pkg::w_beat_t             packed_beat;
  logic                           head_valid;
  logic                           seq_deq;
  logic                           fifo_push;
  logic                           fifo_merge;
  logic                           fifo_full;
  logic [store_pkg::BUS_NB_W:0]   bus_cnt;
  logic [store_pkg::SEQ_NB_W-1:0] seq_ptr;

  seq_buffer u_seq_buffer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rx_valid_i   (rx_deshfu_valid_i),
    .rx_ready_o   (rx_deshfu_ready_o),
    .rx_entry_i   (rx_deshfu_i),
    .deq_i        (seq_deq),
    .head_valid_o (head_valid),
    .head_o       (head)
  );

  nibble_cursor u_nibble_cursor (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .cmd_i     (cursor_cmd),
    .bus_cnt_o (bus_cnt),
    .seq_ptr_o (seq_ptr)
  );

  store_commit_fsm u_store_commit_fsm (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .meta_valid_i (meta_valid_i),
    .meta_ready_o (meta_ready_o),
    .meta_i       (meta_i),
    .txn_valid_i  (txn_valid_i),
    .txn_ready_o  (txn_ready_o),
    .txn_i        (txn_i),
    .head_valid_i (head_valid),
    .fifo_full_i  (fifo_full),
    .bus_cnt_i    (bus_cnt),
    .seq_ptr_i    (seq_ptr),
    .cursor_cmd_o (cursor_cmd),
    .win_o        (win),
    .seq_deq_o    (seq_deq),
    .fifo_push_o  (fifo_push),
    .fifo_merge_o (fifo_merge)
  );

  beat_packer u_beat_packer (
    .win_i       (win),
    .entry_i     (head),
    .beat_last_i (txn_i.is_last),
    .beat_o      (packed_beat)
  );

  w_beat_fifo u_w_beat_fifo (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .merge_i   (fifo_merge),
    .push_i    (fifo_push),
    .beat_i    (packed_beat),
    .full_o    (fifo_full),
    .w_valid_o (axi_w_valid_o),
    .w_ready_i (axi_w_ready_i),
    .w_o       (axi_w_o)
  );

endmodule

`default_nettype wire

//--- logic/w_beat_fifo.sv
// W beat FIFO with a staging register for split beats
// Two-deep ring whose head drives the AXI W channel

`timescale 1ns/1ps
`default_nettype none

module w_beat_fifo (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,

  input  wire logic               merge_i,
  input  wire logic               push_i,
  input  wire store_pkg::w_beat_t beat_i,
  output logic                    full_o,

  // AXI W
  output logic                    w_valid_o,
  input  wire logic               w_ready_i,
  output store_pkg::w_beat_t      w_o
);

  store_pkg::w_beat_t stage_q;
  store_pkg::w_beat_t merged;
  store_pkg::w_beat_t ring_q [2];

  // Bit 1 is the wrap flag
  logic [1:0] wr_ptr_q;
  logic [1:0] rd_ptr_q;
  logic       empty;
  logic       pop;

  // Parts of a split beat occupy disjoint nibbles, so OR joins them
  assign merged = stage_q | beat_i;

  assign empty  = wr_ptr_q == rd_ptr_q;
  assign full_o = (wr_ptr_q[0] == rd_ptr_q[0]) && (wr_ptr_q[1] != rd_ptr_q[1]);

  assign w_valid_o = !empty;
  assign w_o       = ring_q[rd_ptr_q[0]];
  assign pop       = w_valid_o && w_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage_q  <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push_i) begin
        stage_q  <= '0;
        wr_ptr_q <= wr_ptr_q + 2'd1;
      end else if (merge_i) begin
        stage_q <= merged;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      ring_q[wr_ptr_q[0]] <= merged;
    end
  end

endmodule

`default_nettype wire

//--- logic/beat_packer.sv
// Beat packer for the store path
// Moves a window of entry nibbles onto the bus and derives byte strobes

`timescale 1ns/1ps
`default_nettype none

module beat_packer (
  input  wire store_pkg::pack_win_t  win_i,
  input  wire store_pkg::seq_entry_t entry_i,
  input  wire logic                  beat_last_i,
  output store_pkg::w_beat_t         beat_o
);

  logic [store_pkg::BUS_NIBBLES-1:0][3:0] nb;
  logic [store_pkg::BUS_NIBBLES-1:0]      en;
  logic [store_pkg::SEQ_NB_W-1:0]         idx;

  always_comb begin
    nb  = '0;
    en  = '0;
    idx = '0;
    for (int i = 0; i < store_pkg::BUS_NIBBLES; i++) begin
      if ((i >= win_i.start) && (i < win_i.upper)) begin
        // Bus nibble i maps to entry nibble i - start + seq_ptr
        idx   = store_pkg::SEQ_NB_W'(i) - win_i.start + win_i.seq_ptr;
        nb[i] = entry_i.nb[idx];
        en[i] = entry_i.en[idx];
      end
    end
  end

  // A byte is written if either of its nibbles is enabled
  always_comb begin
    beat_o.strb = '0;
    for (int k = 0; k < store_pkg::BUS_BYTES; k++) begin
      beat_o.strb[k] = en[2*k] | en[2*k+1];
    end
  end

  assign beat_o.data = nb;
  assign beat_o.last = beat_last_i;

endmodule

`default_nettype wire

//--- logic/store_commit_fsm.sv
// Commit state machine for the sequential store path
// Holds the meta register, decides each commit step and splits beats across entries

`timescale 1ns/1ps
`default_nettype none

module store_commit_fsm (
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,

  input  wire logic                       meta_valid_i,
  output logic                            meta_ready_o,
  input  wire store_pkg::meta_t           meta_i,

  input  wire logic                       txn_valid_i,
  output logic                            txn_ready_o,
  input  wire store_pkg::txn_beat_t       txn_i,

  input  wire logic                       head_valid_i,
  input  wire logic                       fifo_full_i,
  input  wire logic [store_pkg::BUS_NB_W:0]   bus_cnt_i,
  input  wire logic [store_pkg::SEQ_NB_W-1:0] seq_ptr_i,

  output store_pkg::cursor_cmd_t          cursor_cmd_o,
  output store_pkg::pack_win_t            win_o,
  output logic                            seq_deq_o,
  output logic                            fifo_push_o,
  output logic                            fifo_merge_o
);

  typedef enum logic {
    IDLE,
    COMMIT
  } state_e;

  state_e state_q;
  state_e state_d;

  store_pkg::meta_t meta_q;
  logic             meta_full_q;
  logic             meta_take;
  logic [11:0]      vstart_nb;

  logic [store_pkg::BUS_NB_W:0] lower;
  logic [store_pkg::BUS_NB_W:0] upper;
  logic [store_pkg::BUS_NB_W:0] bus_need;
  logic [store_pkg::BUS_NB_W:0] start;
  logic [store_pkg::BUS_NB_W:0] commit_cnt;
  logic [store_pkg::SEQ_NB_W:0] seq_left;
  logic                         step;
  logic                         split;
  logic                         exact;

  // ==========================================================================
  // Meta register
  // ==========================================================================
  assign meta_ready_o = !meta_full_q;
  assign meta_take    = (state_q == IDLE) && txn_valid_i && meta_full_q;

  // First nibble of the request as vstart scaled to nibbles
  assign vstart_nb = {4'b0, meta_q.vstart} << ({1'b0, meta_q.eew} + 3'd1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      meta_full_q <= 1'b0;
    end else if (meta_valid_i && meta_ready_o) begin
      meta_full_q <= 1'b1;
    end else if (meta_take) begin
      meta_full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (meta_valid_i && meta_ready_o) begin
      meta_q <= meta_i;
    end
  end

  // ==========================================================================
  // Step arithmetic
  // ==========================================================================
  assign lower    = txn_i.is_head ? {1'b0, txn_i.addr_off} : '0;
  assign upper    = txn_i.is_last ? txn_i.lbn
                                  : (store_pkg::BUS_NB_W + 1)'(store_pkg::BUS_NIBBLES);
  assign bus_need = upper - lower - bus_cnt_i;
  assign seq_left = (store_pkg::SEQ_NB_W + 1)'(store_pkg::SEQ_NIBBLES) - {1'b0, seq_ptr_i};
  assign split    = {1'b0, bus_need} > seq_left;
  assign exact    = {1'b0, bus_need} == seq_left;

  // Split only happens when the entry holds fewer than a full beat
  assign commit_cnt = split ? seq_left[store_pkg::BUS_NB_W:0] : bus_need;
  assign start      = lower + bus_cnt_i;
  assign step       = (state_q == COMMIT) && head_valid_i && !fifo_full_i && txn_valid_i;

  assign win_o.start   = start;
  assign win_o.upper   = start + commit_cnt;
  assign win_o.seq_ptr = seq_ptr_i;

  always_comb begin
    state_d      = state_q;
    cursor_cmd_o = '0;
    seq_deq_o    = 1'b0;
    fifo_push_o  = 1'b0;
    fifo_merge_o = 1'b0;
    txn_ready_o  = 1'b0;

    if (meta_take) begin
      cursor_cmd_o.load     = 1'b1;
      cursor_cmd_o.load_ptr = vstart_nb[store_pkg::SEQ_NB_W-1:0];
      state_d               = COMMIT;
    end

    if (step) begin
      cursor_cmd_o.advance = 1'b1;
      cursor_cmd_o.adv_cnt = commit_cnt;
      if (split) begin
        // Take the rest of this entry, finish the beat from the next one
        cursor_cmd_o.seq_clear = 1'b1;
        seq_deq_o              = 1'b1;
        fifo_merge_o           = 1'b1;
      end else begin
        cursor_cmd_o.bus_clear = 1'b1;
        fifo_push_o            = 1'b1;
        txn_ready_o            = 1'b1;
        // Leftover nibbles after the final beat are dropped
        if (exact || txn_i.is_final) begin
          cursor_cmd_o.seq_clear = 1'b1;
          seq_deq_o              = 1'b1;
        end
        if (txn_i.is_final) begin
          state_d = IDLE;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

//--- logic/nibble_cursor.sv
// Nibble cursor for the store commit path
// Tracks nibbles placed in the current bus beat and the read pointer in the head entry

`timescale 1ns/1ps
`default_nettype none

module nibble_cursor (
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,
  input  wire store_pkg::cursor_cmd_t     cmd_i,
  output logic [store_pkg::BUS_NB_W:0]    bus_cnt_o,
  output logic [store_pkg::SEQ_NB_W-1:0]  seq_ptr_o
);

  logic [store_pkg::BUS_NB_W:0]   bus_cnt_q;
  logic [store_pkg::BUS_NB_W:0]   bus_cnt_d;
  logic [store_pkg::SEQ_NB_W-1:0] seq_ptr_q;
  logic [store_pkg::SEQ_NB_W-1:0] seq_ptr_d;

  always_comb begin
    bus_cnt_d = bus_cnt_q;
    seq_ptr_d = seq_ptr_q;

    if (cmd_i.load) begin
      bus_cnt_d = '0;
      seq_ptr_d = cmd_i.load_ptr;
    end else begin
      if (cmd_i.advance) begin
        bus_cnt_d = bus_cnt_q + cmd_i.adv_cnt;
        // Pointer wraps modulo the entry size
        seq_ptr_d = seq_ptr_q + cmd_i.adv_cnt[store_pkg::SEQ_NB_W-1:0];
      end
      // Clears win over the advance
      if (cmd_i.bus_clear) begin
        bus_cnt_d = '0;
      end
      if (cmd_i.seq_clear) begin
        seq_ptr_d = '0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bus_cnt_q <= '0;
      seq_ptr_q <= '0;
    end else begin
      bus_cnt_q <= bus_cnt_d;
      seq_ptr_q <= seq_ptr_d;
    end
  end

  assign bus_cnt_o = bus_cnt_q;
  assign seq_ptr_o = seq_ptr_q;

endmodule

`default_nettype wire

//--- logic/seq_buffer.sv
// Two-slot ping-pong buffer for sequential entries
// Pointers carry a wrap flag so full and empty can be told apart

`timescale 1ns/1ps
`default_nettype none

module seq_buffer (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,

  // Entries from the deshuffle unit
  input  wire logic                 rx_valid_i,
  output logic                      rx_ready_o,
  input  wire store_pkg::seq_entry_t rx_entry_i,

  // Head slot towards the commit logic
  input  wire logic                 deq_i,
  output logic                      head_valid_o,
  output store_pkg::seq_entry_t     head_o
);

  store_pkg::seq_entry_t slot_q [2];

  // Bit 1 is the wrap flag, bit 0 selects the slot
  logic [1:0] enq_ptr_q;
  logic [1:0] deq_ptr_q;
  logic       same_slot;
  logic       empty;
  logic       full;
  logic       enq;

  assign same_slot = enq_ptr_q[0] == deq_ptr_q[0];
  assign empty     = same_slot && (enq_ptr_q[1] == deq_ptr_q[1]);
  assign full      = same_slot && (enq_ptr_q[1] != deq_ptr_q[1]);

  assign rx_ready_o = !full;
  assign enq        = rx_valid_i && rx_ready_o;

  assign head_valid_o = !empty;
  assign head_o       = slot_q[deq_ptr_q[0]];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enq_ptr_q <= '0;
      deq_ptr_q <= '0;
    end else begin
      if (enq) begin
        enq_ptr_q <= enq_ptr_q + 2'd1;
      end
      if (deq_i) begin
        deq_ptr_q <= deq_ptr_q + 2'd1;
      end
    end
  end

  // Slot storage
  always_ff @(posedge clk_i) begin
    if (enq) begin
      slot_q[enq_ptr_q[0]] <= rx_entry_i;
    end
  end

endmodule

`default_nettype wire

//--- logic/store_pkg.sv
// Shared sizes and packed structs for the vector store data path
// Covers sequential entries, per-beat control, meta, W beats and internal commands

`default_nettype none

package store_pkg;

  // ==========================================================================
  // Bus and buffer sizes
  // ==========================================================================
  localparam int unsigned BUS_NIBBLES = 16;
  localparam int unsigned BUS_BYTES   = 8;
  localparam int unsigned BUS_NB_W    = 4;
  localparam int unsigned SEQ_NIBBLES = 32;
  localparam int unsigned SEQ_NB_W    = 5;

  // ==========================================================================
  // External words
  // ==========================================================================

  // One deshuffled entry of two 64-bit lanes
  typedef struct packed {
    logic [SEQ_NIBBLES-1:0][3:0] nb;
    logic [SEQ_NIBBLES-1:0]      en;
  } seq_entry_t;

  // Control for one bus beat
  typedef struct packed {
    logic [BUS_NB_W-1:0] addr_off;
    logic                is_head;
    logic [BUS_NB_W:0]   lbn;
    logic                is_last;
    logic                is_final;
  } txn_beat_t;

  // Request meta with eew as log2 of the element size in bytes
  typedef struct packed {
    logic [7:0] vstart;
    logic [1:0] eew;
  } meta_t;

  typedef struct packed {
    logic [4*BUS_NIBBLES-1:0] data;
    logic [BUS_BYTES-1:0]     strb;
    logic                     last;
  } w_beat_t;

  // ==========================================================================
  // Internal commands
  // ==========================================================================
  typedef struct packed {
    logic                load;
    logic [SEQ_NB_W-1:0] load_ptr;
    logic                advance;
    logic [BUS_NB_W:0]   adv_cnt;
    logic                bus_clear;
    logic                seq_clear;
  } cursor_cmd_t;

  // Bus window [start, upper) filled from the entry at seq_ptr
  typedef struct packed {
    logic [BUS_NB_W:0]   start;
    logic [BUS_NB_W:0]   upper;
    logic [SEQ_NB_W-1:0] seq_ptr;
  } pack_win_t;

endpackage

`default_nettype wire
